// File: rtl/la_io_pkg.sv
`default_nettype none

package la_io_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam logic [ADDR_W-1:0] REG_LED_ADDR      = 8'h00;
    localparam logic [ADDR_W-1:0] REG_TMR_ADDR      = 8'h04;
    localparam logic [ADDR_W-1:0] REG_SPI_CTRL_ADDR = 8'h08;
    localparam logic [ADDR_W-1:0] REG_SPI_DATA_ADDR = 8'h0C;

    localparam int LED_W = 3;
    localparam logic [LED_W-1:0] LED_RESET = 3'd4;

    // Clocks per microsecond at 48 MHz
    localparam int TMR_PRESCALE = 48;
    localparam int SPI_BITS     = 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    typedef enum logic [2:0] {
        SEL_LED,
        SEL_TMR,
        SEL_SPI_CTRL,
        SEL_SPI_DATA,
        SEL_NONE
    } reg_sel_t;

endpackage

`default_nettype wire

// File: rtl/io_req_if.sv
`timescale 1ns/100ps
`default_nettype none

// Decoded register request, one cycle wide
interface io_req_if import la_io_pkg::*; ();

    logic              valid;
    logic              we;
    reg_sel_t          sel;
    logic [DATA_W-1:0] wdata;
    logic              byte0_en;

    modport decode_mp (
        output valid,
        output we,
        output sel,
        output wdata,
        output byte0_en
    );

    modport execute_mp (
        input valid,
        input we,
        input sel,
        input wdata,
        input byte0_en
    );

endinterface

`default_nettype wire

// File: rtl/io_rsp_if.sv
`timescale 1ns/100ps
`default_nettype none

interface io_rsp_if import la_io_pkg::*; ();

    logic              valid;
    logic              we;
    logic [DATA_W-1:0] rdata;
    resp_t             resp;

    modport execute_mp (
        output valid,
        output we,
        output rdata,
        output resp
    );

    modport result_mp (
        input valid,
        input we,
        input rdata,
        input resp
    );

endinterface

`default_nettype wire

// File: rtl/spi_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module spi_shifter import la_io_pkg::*; (
    input  wire logic                clk_48,
    input  wire logic                rst_n,
    input  wire logic                cs_wr,
    input  wire logic                cs_val,
    input  wire logic                start,
    input  wire logic [SPI_BITS-1:0] tx_byte,
    output logic                     busy,
    output logic [SPI_BITS-1:0]      rx_byte,
    output logic                     spi_cs,
    output logic                     spi_clk,
    output logic                     spi_mosi,
    input  wire logic                spi_miso
);

    localparam int CNT_W = $clog2(SPI_BITS + 1);

    logic [CNT_W-1:0] bit_cnt;

    // Still busy while the last rising edge is pending
    assign busy = (bit_cnt != '0) || !spi_clk;

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            spi_cs   <= 1'b1;
            spi_clk  <= 1'b1;
            spi_mosi <= 1'b1;
            bit_cnt  <= '0;
            rx_byte  <= '0;
        end else begin
            if (cs_wr)
                spi_cs <= cs_val;

            if (!spi_clk) begin
                // Sample on the rising edge
                rx_byte[0] <= spi_miso;
                spi_clk    <= 1'b1;
            end else if (start) begin
                rx_byte <= tx_byte;
                bit_cnt <= CNT_W'(SPI_BITS);
            end else if (bit_cnt != '0) begin
                // Shift out MSB first on the falling edge
                spi_mosi <= rx_byte[SPI_BITS-1];
                rx_byte  <= {rx_byte[SPI_BITS-2:0], 1'b0};
                spi_clk  <= 1'b0;
                bit_cnt  <= bit_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/io_axil_decode.sv
`timescale 1ns/100ps
`default_nettype none

module io_axil_decode import la_io_pkg::*; (
    input  wire logic              clk_48,
    input  wire logic              rst_n,

    input  wire logic [ADDR_W-1:0] s_axil_awaddr,
    input  wire logic              s_axil_awvalid,
    output logic                   s_axil_awready,

    input  wire logic [DATA_W-1:0] s_axil_wdata,
    input  wire logic [STRB_W-1:0] s_axil_wstrb,
    input  wire logic              s_axil_wvalid,
    output logic                   s_axil_wready,

    input  wire logic [ADDR_W-1:0] s_axil_araddr,
    input  wire logic              s_axil_arvalid,
    output logic                   s_axil_arready,

    input  wire logic              done,
    io_req_if.decode_mp            req
);

    logic busy;
    logic wr_hs;
    logic rd_hs;

    function automatic reg_sel_t map_sel(input logic [ADDR_W-1:0] addr);
        reg_sel_t sel;
        case ({addr[ADDR_W-1:2], 2'b00})
            REG_LED_ADDR:      sel = SEL_LED;
            REG_TMR_ADDR:      sel = SEL_TMR;
            REG_SPI_CTRL_ADDR: sel = SEL_SPI_CTRL;
            REG_SPI_DATA_ADDR: sel = SEL_SPI_DATA;
            default:           sel = SEL_NONE;
        endcase
        return sel;
    endfunction

    // Address and data are taken together and writes win over reads
    assign s_axil_awready = !busy && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_wready  = s_axil_awready;
    assign s_axil_arready = !busy && !s_axil_awvalid && s_axil_arvalid;

    assign wr_hs = s_axil_awvalid && s_axil_awready;
    assign rd_hs = s_axil_arvalid && s_axil_arready;

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            req.valid <= 1'b0;
            req.we    <= 1'b0;
        end else begin
            req.valid <= wr_hs || rd_hs;
            if (wr_hs || rd_hs) begin
                busy   <= 1'b1;
                req.we <= wr_hs;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_48) begin
        if (wr_hs) begin
            req.sel      <= map_sel(s_axil_awaddr);
            req.wdata    <= s_axil_wdata;
            req.byte0_en <= s_axil_wstrb[0];
        end else if (rd_hs) begin
            req.sel      <= map_sel(s_axil_araddr);
        end
    end

endmodule

`default_nettype wire

// File: rtl/io_execute.sv
`timescale 1ns/100ps
`default_nettype none

module io_execute import la_io_pkg::*; (
    input  wire logic     clk_48,
    input  wire logic     rst_n,
    io_req_if.execute_mp  req,
    io_rsp_if.execute_mp  rsp,
    output logic [LED_W-1:0] led,
    output logic          spi_cs,
    output logic          spi_clk,
    output logic          spi_mosi,
    input  wire logic     spi_miso
);

    localparam int PRE_W = $clog2(TMR_PRESCALE);

    logic [PRE_W-1:0]    tmr_prescale;
    logic [DATA_W-1:0]   tmr_us;
    logic                wr_en;
    logic                spi_busy;
    logic [SPI_BITS-1:0] spi_rx;
    logic [DATA_W-1:0]   rdata_nxt;
    resp_t               resp_nxt;

    assign wr_en = req.valid && req.we && req.byte0_en;

    // ------------------------------------------------------------
    // LED register and microsecond timer
    // ------------------------------------------------------------
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            led          <= LED_RESET;
            tmr_prescale <= '0;
            tmr_us       <= '0;
        end else begin
            if (wr_en && req.sel == SEL_LED)
                led <= req.wdata[LED_W-1:0];
            if (tmr_prescale == PRE_W'(TMR_PRESCALE - 1)) begin
                tmr_prescale <= '0;
                tmr_us       <= tmr_us + 1'b1;
            end else begin
                tmr_prescale <= tmr_prescale + 1'b1;
            end
        end
    end

    spi_shifter u_spi (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .cs_wr    (wr_en && req.sel == SEL_SPI_CTRL),
        .cs_val   (req.wdata[0]),
        .start    (wr_en && req.sel == SEL_SPI_DATA),
        .tx_byte  (req.wdata[SPI_BITS-1:0]),
        .busy     (spi_busy),
        .rx_byte  (spi_rx),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    // ------------------------------------------------------------
    // Read data and response
    // ------------------------------------------------------------
    always_comb begin
        case (req.sel)
            SEL_LED:      rdata_nxt = DATA_W'(led);
            SEL_TMR:      rdata_nxt = tmr_us;
            SEL_SPI_CTRL: rdata_nxt = DATA_W'({spi_busy, spi_cs});
            SEL_SPI_DATA: rdata_nxt = DATA_W'(spi_rx);
            default:      rdata_nxt = '0;
        endcase
        resp_nxt = RESP_OKAY;
        // Timer is read only
        if (req.sel == SEL_NONE || (req.we && req.sel == SEL_TMR))
            resp_nxt = RESP_SLVERR;
    end

    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n)
            rsp.valid <= 1'b0;
        else
            rsp.valid <= req.valid;
    end

    always_ff @(posedge clk_48) begin
        if (req.valid) begin
            rsp.we    <= req.we;
            rsp.rdata <= rdata_nxt;
            rsp.resp  <= resp_nxt;
        end
    end

endmodule

`default_nettype wire

// File: rtl/io_response.sv
`timescale 1ns/100ps
`default_nettype none

module io_response import la_io_pkg::*; (
    input  wire logic        clk_48,
    input  wire logic        rst_n,
    io_rsp_if.result_mp      rsp,

    output logic [1:0]        s_axil_bresp,
    output logic              s_axil_bvalid,
    input  wire logic         s_axil_bready,

    output logic [DATA_W-1:0] s_axil_rdata,
    output logic [1:0]        s_axil_rresp,
    output logic              s_axil_rvalid,
    input  wire logic         s_axil_rready,

    output logic              done
);

    // ------------------------------------------------------------
    // B and R valid held until accepted
    // ------------------------------------------------------------
    always_ff @(posedge clk_48 or negedge rst_n) begin
        if (!rst_n) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (rsp.valid && rsp.we)
                s_axil_bvalid <= 1'b1;
            else if (s_axil_bready)
                s_axil_bvalid <= 1'b0;

            if (rsp.valid && !rsp.we)
                s_axil_rvalid <= 1'b1;
            else if (s_axil_rready)
                s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_48) begin
        if (rsp.valid) begin
            if (rsp.we) begin
                s_axil_bresp <= rsp.resp;
            end else begin
                s_axil_rdata <= rsp.rdata;
                s_axil_rresp <= rsp.resp;
            end
        end
    end

    // Releases decode for the next address
    assign done = (s_axil_bvalid && s_axil_bready) || (s_axil_rvalid && s_axil_rready);

endmodule

`default_nettype wire

// File: rtl/la_io_top.sv
`timescale 1ns/100ps
`default_nettype none

module la_io_top import la_io_pkg::*; (
    input  wire logic              clk_48,
    input  wire logic              rst_n,

    input  wire logic [ADDR_W-1:0] s_axil_awaddr,
    input  wire logic              s_axil_awvalid,
    output logic                   s_axil_awready,
    input  wire logic [DATA_W-1:0] s_axil_wdata,
    input  wire logic [STRB_W-1:0] s_axil_wstrb,
    input  wire logic              s_axil_wvalid,
    output logic                   s_axil_wready,
    output logic [1:0]             s_axil_bresp,
    output logic                   s_axil_bvalid,
    input  wire logic              s_axil_bready,
    input  wire logic [ADDR_W-1:0] s_axil_araddr,
    input  wire logic              s_axil_arvalid,
    output logic                   s_axil_arready,
    output logic [DATA_W-1:0]      s_axil_rdata,
    output logic [1:0]             s_axil_rresp,
    output logic                   s_axil_rvalid,
    input  wire logic              s_axil_rready,

    output logic                   spi_cs,
    output logic                   spi_clk,
    output logic                   spi_mosi,
    input  wire logic              spi_miso,

    output logic [LED_W-1:0]       led
);

    logic done;

    io_req_if req_bus ();
    io_rsp_if rsp_bus ();

    io_axil_decode u_decode (
        .clk_48         (clk_48),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .done           (done),
        .req            (req_bus.decode_mp)
    );

    io_execute u_execute (
        .clk_48   (clk_48),
        .rst_n    (rst_n),
        .req      (req_bus.execute_mp),
        .rsp      (rsp_bus.execute_mp),
        .led      (led),
        .spi_cs   (spi_cs),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    io_response u_response (
        .clk_48        (clk_48),
        .rst_n         (rst_n),
        .rsp           (rsp_bus.result_mp),
        .s_axil_bresp  (s_axil_bresp),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready),
        .done          (done)
    );

endmodule

`default_nettype wire

// File: test/la_io_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module la_io_asserts import la_io_pkg::*; (
    input wire logic              clk_48,
    input wire logic              rst_n,
    input wire logic              rsp_valid,
    input wire logic              bvalid,
    input wire logic              bready,
    input wire logic [1:0]        bresp,
    input wire logic              rvalid,
    input wire logic              rready,
    input wire logic [1:0]        rresp,
    input wire logic [DATA_W-1:0] rdata
);

    int assert_fails = 0;

    // Only one transaction in flight
    one_channel: assert property (@(posedge clk_48) disable iff (!rst_n)
        !(bvalid && rvalid))
        else begin
            $error("bvalid and rvalid high together");
            assert_fails++;
        end

    b_hold: assert property (@(posedge clk_48) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("B channel changed while stalled");
            assert_fails++;
        end

    r_hold: assert property (@(posedge clk_48) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else begin
            $error("R channel changed while stalled");
            assert_fails++;
        end

    // New result only once the previous response is gone
    one_result: assert property (@(posedge clk_48) disable iff (!rst_n)
        rsp_valid |-> !bvalid && !rvalid)
        else begin
            $error("result arrived while a response was still waiting");
            assert_fails++;
        end

endmodule

`default_nettype wire

// File: test/la_io_checker.sv
`timescale 1ns/100ps
`default_nettype none

module la_io_checker import la_io_pkg::*; (
    input wire logic              clk_48,
    input wire logic              rst_n,
    input wire logic [1:0]        bresp,
    input wire logic              bvalid,
    input wire logic              bready,
    input wire logic [DATA_W-1:0] rdata,
    input wire logic [1:0]        rresp,
    input wire logic              rvalid,
    input wire logic              rready,
    input wire logic [LED_W-1:0]  led,
    input wire logic              spi_cs,
    input wire logic              spi_clk
);

    int                pass_cnt = 0;
    int                fail_cnt = 0;
    int                spi_falls = 0;
    logic              pending = 1'b0;
    logic              exp_wr = 1'b0;
    logic [1:0]        exp_resp = '0;
    logic [DATA_W-1:0] exp_data = '0;
    logic              exp_care = 1'b0;
    string             cur_name = "";
    logic [DATA_W-1:0] last_rdata = '0;
    logic [DATA_W-1:0] tmr_mark = '0;
    logic              b_hs;
    logic              r_hs;

    assign b_hs = bvalid && bready;
    assign r_hs = rvalid && rready;

    task automatic record_result(input string name, input bit ok, input string msg);
        if (ok) begin
            pass_cnt++;
            $display("  passed  %s", name);
        end else begin
            fail_cnt++;
            $display("CHECK FAILED at %0t: %s: %s", $time, name, msg);
        end
    endtask

    task automatic report_error(input string msg);
        fail_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic expect_txn(input string name, input bit is_wr, input logic [1:0] resp,
                              input logic [DATA_W-1:0] data, input bit care);
        cur_name = name;
        exp_wr   = is_wr;
        exp_resp = resp;
        exp_data = data;
        exp_care = care;
        pending  = 1'b1;
    endtask

    // ------------------------------------------------------------
    // B and R handshakes
    // ------------------------------------------------------------
    always @(posedge clk_48) begin : watch_responses
        logic [1:0] got;
        if (rst_n && (b_hs || r_hs)) begin
            got = b_hs ? bresp : rresp;
            if (!pending)
                report_error("a response arrived with no transaction outstanding");
            else if (b_hs && r_hs)
                report_error("write and read responses arrived in the same cycle");
            else if (b_hs != exp_wr)
                record_result(cur_name, 1'b0, "response on the wrong channel");
            else if (got !== exp_resp)
                record_result(cur_name, 1'b0,
                              $sformatf("resp %0d, expected %0d", got, exp_resp));
            else if (r_hs && exp_care && rdata !== exp_data)
                record_result(cur_name, 1'b0,
                              $sformatf("rdata 0x%08h, expected 0x%08h", rdata, exp_data));
            else
                record_result(cur_name, 1'b1, "");
            pending = 1'b0;
            if (r_hs)
                last_rdata = rdata;
        end
    end

    always @(negedge spi_clk) begin
        if (rst_n)
            spi_falls++;
    end

    task automatic check_pins(input string name, input logic [LED_W-1:0] led_exp,
                              input logic cs_exp);
        record_result(name, led === led_exp && spi_cs === cs_exp,
                      $sformatf("led %0d cs %b, expected led %0d cs %b",
                                led, spi_cs, led_exp, cs_exp));
    endtask

    task automatic mark_timer();
        tmr_mark = last_rdata;
    endtask

    // Rounded microseconds with one of slack either way
    task automatic check_timer(input string name, input int cycles);
        int exp_us;
        int got_us;
        exp_us = (cycles + TMR_PRESCALE / 2) / TMR_PRESCALE;
        got_us = int'(last_rdata - tmr_mark);
        record_result(name, got_us >= exp_us - 1 && got_us <= exp_us + 1,
                      $sformatf("timer moved %0d us over %0d clocks, expected %0d",
                                got_us, cycles, exp_us));
    endtask

    task automatic clear_spi_edges();
        spi_falls = 0;
    endtask

    task automatic check_spi_edges(input string name);
        record_result(name, spi_falls == SPI_BITS,
                      $sformatf("%0d falling spi_clk edges, expected %0d",
                                spi_falls, SPI_BITS));
    endtask

    task automatic report_totals();
        $display("Totals: %0d passed, %0d failed", pass_cnt, fail_cnt);
    endtask

endmodule

`default_nettype wire

// File: test/tb_la_io.sv
`timescale 1ns/100ps
`default_nettype none

module tb_la_io import la_io_pkg::*; ();

    typedef enum logic [3:0] {
        OP_WR, OP_RD, OP_PINS, OP_IDLE, OP_TMR_MARK,
        OP_TMR_DELTA, OP_SPI_WR, OP_SPI_POLL, OP_SPI_RD
    } op_t;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [1:0]        resp;
        logic [DATA_W-1:0] data;
        logic              care;
    } entry_t;

    logic                clk_48 = 1'b0;
    logic                rst_n;
    logic [ADDR_W-1:0]   s_axil_awaddr;
    logic                s_axil_awvalid;
    logic                s_axil_awready;
    logic [DATA_W-1:0]   s_axil_wdata;
    logic [STRB_W-1:0]   s_axil_wstrb;
    logic                s_axil_wvalid;
    logic                s_axil_wready;
    logic [1:0]          s_axil_bresp;
    logic                s_axil_bvalid;
    logic                s_axil_bready;
    logic [ADDR_W-1:0]   s_axil_araddr;
    logic                s_axil_arvalid;
    logic                s_axil_arready;
    logic [DATA_W-1:0]   s_axil_rdata;
    logic [1:0]          s_axil_rresp;
    logic                s_axil_rvalid;
    logic                s_axil_rready;
    logic                spi_cs;
    logic                spi_clk;
    logic                spi_mosi;
    logic                spi_miso;
    logic [LED_W-1:0]    led;

    entry_t              tbl[$];
    int                  n_entries = 0;
    int                  seed = 32'h35c8;
    int                  cyc = 0;
    int                  hs_cyc;
    int                  mark_cyc;
    logic [DATA_W-1:0]   rd_data;
    logic [SPI_BITS-1:0] spi_byte;

    // Loopback so every transfer returns its own byte
    assign spi_miso = spi_mosi;

    always #5 clk_48 = ~clk_48;

    always @(posedge clk_48) cyc <= cyc + 1;

    la_io_top uut (.*);

    la_io_checker chk (
        .clk_48 (clk_48),
        .rst_n  (rst_n),
        .bresp  (s_axil_bresp),
        .bvalid (s_axil_bvalid),
        .bready (s_axil_bready),
        .rdata  (s_axil_rdata),
        .rresp  (s_axil_rresp),
        .rvalid (s_axil_rvalid),
        .rready (s_axil_rready),
        .led    (led),
        .spi_cs (spi_cs),
        .spi_clk(spi_clk)
    );

    bind io_response la_io_asserts u_asserts (
        .clk_48    (clk_48),
        .rst_n     (rst_n),
        .rsp_valid (rsp.valid),
        .bvalid    (s_axil_bvalid),
        .bready    (s_axil_bready),
        .bresp     (s_axil_bresp),
        .rvalid    (s_axil_rvalid),
        .rready    (s_axil_rready),
        .rresp     (s_axil_rresp),
        .rdata     (s_axil_rdata)
    );

    task automatic add_entry(input op_t op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                             input logic [1:0] resp, input logic [DATA_W-1:0] data,
                             input logic care);
        tbl.push_back(entry_t'{op, addr, wdata, strb, resp, data, care});
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    // Pins entries pack {cs, led} into data
    task automatic build_table();
        add_entry(OP_RD,        REG_LED_ADDR,      0,     4'hf, RESP_OKAY,   4,      1);
        add_entry(OP_PINS,      0,                 0,     0,    RESP_OKAY,   4'hc,   1);
        add_entry(OP_WR,        REG_LED_ADDR,      3,     4'hf, RESP_OKAY,   0,      0);
        add_entry(OP_RD,        REG_LED_ADDR,      0,     4'hf, RESP_OKAY,   3,      1);
        add_entry(OP_PINS,      0,                 0,     0,    RESP_OKAY,   4'hb,   1);
        add_entry(OP_WR,        REG_LED_ADDR,      5,     4'he, RESP_OKAY,   0,      0);
        add_entry(OP_RD,        REG_LED_ADDR,      0,     4'hf, RESP_OKAY,   3,      1);
        add_entry(OP_TMR_MARK,  REG_TMR_ADDR,      0,     0,    RESP_OKAY,   0,      0);
        add_entry(OP_IDLE,      0,                 300,   0,    RESP_OKAY,   0,      0);
        add_entry(OP_TMR_DELTA, REG_TMR_ADDR,      0,     0,    RESP_OKAY,   0,      0);
        add_entry(OP_WR,        REG_TMR_ADDR,      'h55,  4'hf, RESP_SLVERR, 0,      0);
        add_entry(OP_WR,        REG_SPI_CTRL_ADDR, 0,     4'hf, RESP_OKAY,   0,      0);
        add_entry(OP_RD,        REG_SPI_CTRL_ADDR, 0,     4'hf, RESP_OKAY,   0,      1);
        add_entry(OP_PINS,      0,                 0,     0,    RESP_OKAY,   4'h3,   1);
        add_entry(OP_WR,        REG_SPI_CTRL_ADDR, 1,     4'hf, RESP_OKAY,   0,      0);
        add_entry(OP_RD,        REG_SPI_CTRL_ADDR, 0,     4'hf, RESP_OKAY,   1,      1);
        add_entry(OP_PINS,      0,                 0,     0,    RESP_OKAY,   4'hb,   1);
        for (int k = 0; k < 2; k++) begin
            add_entry(OP_SPI_WR,   REG_SPI_DATA_ADDR, 0, 4'hf, RESP_OKAY, 0, 0);
            add_entry(OP_SPI_POLL, REG_SPI_CTRL_ADDR, 0, 4'hf, RESP_OKAY, 0, 0);
            add_entry(OP_SPI_RD,   REG_SPI_DATA_ADDR, 0, 4'hf, RESP_OKAY, 0, 1);
        end
        add_entry(OP_RD,        8'h10,             0,     4'hf, RESP_SLVERR, 0,      1);
        add_entry(OP_WR,        8'h10,             'h77,  4'hf, RESP_SLVERR, 0,      0);
        add_entry(OP_RD,        8'hfc,             0,     4'hf, RESP_SLVERR, 0,      1);
        add_entry(OP_WR,        8'hfc,             'h77,  4'hf, RESP_SLVERR, 0,      0);
    endtask

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb);
        int stall;
        stall = $unsigned($random(seed)) % 4;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        do @(posedge clk_48); while (!s_axil_awready);
        hs_cyc = cyc;
        if (!s_axil_wready)
            chk.report_error("wready was low at the write address handshake");
        @(negedge clk_48);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        while (!s_axil_bvalid) @(negedge clk_48);
        repeat (stall) @(negedge clk_48);
        s_axil_bready = 1'b1;
        @(posedge clk_48);
        @(negedge clk_48);
        s_axil_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr);
        int stall;
        stall = $unsigned($random(seed)) % 4;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        do @(posedge clk_48); while (!s_axil_arready);
        hs_cyc = cyc;
        @(negedge clk_48);
        s_axil_arvalid = 1'b0;
        while (!s_axil_rvalid) @(negedge clk_48);
        repeat (stall) @(negedge clk_48);
        s_axil_rready = 1'b1;
        @(posedge clk_48);
        rd_data = s_axil_rdata;
        @(negedge clk_48);
        s_axil_rready = 1'b0;
    endtask

    task automatic run_entry(input entry_t e, input string name);
        int polls;
        case (e.op)
            OP_WR: begin
                chk.expect_txn(name, 1'b1, e.resp, '0, 1'b0);
                axi_write(e.addr, e.wdata, e.strb);
            end
            OP_RD: begin
                chk.expect_txn(name, 1'b0, e.resp, e.data, e.care);
                axi_read(e.addr);
            end
            OP_PINS:
                chk.check_pins(name, e.data[LED_W-1:0], e.data[LED_W]);
            OP_IDLE:
                repeat (e.wdata) @(negedge clk_48);
            OP_TMR_MARK: begin
                chk.expect_txn(name, 1'b0, RESP_OKAY, '0, 1'b0);
                axi_read(e.addr);
                mark_cyc = hs_cyc;
                chk.mark_timer();
            end
            OP_TMR_DELTA: begin
                chk.expect_txn(name, 1'b0, RESP_OKAY, '0, 1'b0);
                axi_read(e.addr);
                chk.check_timer(name, hs_cyc - mark_cyc);
            end
            OP_SPI_WR: begin
                spi_byte = $random(seed);
                chk.clear_spi_edges();
                chk.expect_txn(name, 1'b1, RESP_OKAY, '0, 1'b0);
                axi_write(e.addr, DATA_W'(spi_byte), e.strb);
            end
            OP_SPI_POLL: begin
                polls = 0;
                do begin
                    chk.expect_txn(name, 1'b0, RESP_OKAY, '0, 1'b0);
                    axi_read(e.addr);
                    polls++;
                end while (rd_data[1] && polls < 20);
                if (rd_data[1])
                    chk.report_error("SPI busy was still set after 20 polls");
            end
            OP_SPI_RD: begin
                chk.expect_txn(name, 1'b0, RESP_OKAY, DATA_W'(spi_byte), 1'b1);
                axi_read(e.addr);
                chk.check_spi_edges(name);
            end
            default:
                chk.report_error("unknown table entry");
        endcase
    endtask

    initial begin
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        build_table();
        n_entries = tbl.size();
        repeat (8) @(posedge clk_48);
        @(negedge clk_48);
        rst_n = 1'b1;
        @(negedge clk_48);
        for (int i = 0; i < tbl.size(); i++)
            run_entry(tbl[i], $sformatf("%0d %s 0x%02h", i, tbl[i].op.name(), tbl[i].addr));
        repeat (4) @(negedge clk_48);
        chk.report_totals();
        if (chk.fail_cnt == 0 && uut.u_response.u_asserts.assert_fails == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_entries != 0);
        repeat (n_entries * 60 + 8) @(posedge clk_48);
        $display("Timeout: the tests did not finish within %0d entries of 60 cycles",
                 n_entries);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/la_io_pkg.sv
rtl/io_req_if.sv
rtl/io_rsp_if.sv
rtl/spi_shifter.sv
rtl/io_axil_decode.sv
rtl/io_execute.sv
rtl/io_response.sv
rtl/la_io_top.sv
test/la_io_asserts.sv
test/la_io_checker.sv
test/tb_la_io.sv
